// ==== build.sh ====
#!/bin/sh
# compile with verilator, run the testbench, then decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -j 0 --top-module tb_cpu_system -f project.f -o tb_cpu_system \
  && ./obj_dir/tb_cpu_system | tee sim.log \
  || { echo "build or simulation run did not complete"; exit 1; }

grep -q "all tests passed" sim.log && echo "result: PASS" \
  || { echo "result: FAIL"; exit 1; }

// ==== project.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/boot_memory.sv
rtl/cpu_core.sv
rtl/cpu_system.sv
sim/tb_cpu_system.sv

// ==== rtl/boot_memory.sv ====
// port b is write-only and wins a same-address collision; port a reads old data on a write
`default_nettype none

`include "cpu_cfg.svh"

module boot_memory
(
  input  wire                CLK,
  input  wire bus_pkg::mem_req_t a_req,
  output bus_pkg::word_t     a_rdata,
  input  wire bus_pkg::mem_req_t b_req
);
  import bus_pkg::*;

  localparam int DEPTH = 1 << `CPU_ADDRESS_BITS;

  word_t mem [DEPTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // boot program
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // counts 5 down to 1 on port 1, then halts
  // word 128 holds the step, word 129 the counter
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
    begin
      mem[i] = '0;
    end
    mem[0]   = 16'h1005;  // ldi 5
    mem[1]   = 16'h3081;  // st  129
    mem[2]   = 16'h2081;  // ld  129
    mem[3]   = 16'hb001;  // out 1
    mem[4]   = 16'h5080;  // sub 128
    mem[5]   = 16'h3081;  // st  129
    mem[6]   = 16'ha008;  // jz  8
    mem[7]   = 16'h9002;  // jmp 2
    mem[8]   = 16'hf000;  // halt
    mem[128] = 16'h0001;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge CLK)
  begin
    if (b_req.wr)
    begin
      mem[b_req.address] <= b_req.data;  // host first
    end
    else if (a_req.wr)
    begin
      mem[a_req.address] <= a_req.data;
    end
    a_rdata <= mem[a_req.address];
  end

endmodule

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
// plain strobe buses only; no handshake, an output write must be taken in its cycle
`default_nettype none

`include "cpu_cfg.svh"

package bus_pkg;

  typedef logic [`CPU_WORD_BITS-1:0]    word_t;
  typedef logic [`CPU_ADDRESS_BITS-1:0] address_t;
  typedef logic [`CPU_PORT_BITS-1:0]    port_t;

  // one access on a memory port
  typedef struct packed {
    logic     wr;
    address_t address;
    word_t    data;
  } mem_req_t;

  typedef struct packed {
    port_t port;
    word_t data;
  } io_write_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_cfg.svh ====
// global sizes; address and port widths must stay at or below the 12-bit operand field
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// data word and instruction word share one width
`define CPU_WORD_BITS 16

// memory depth is 1 << address bits
`define CPU_ADDRESS_BITS 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i/o
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// output port number space
`define CPU_PORT_BITS 8

`endif

// ==== rtl/cpu_core.sv ====
// three cycles per instruction; accumulator and zero flag survive start, only reset clears them
`default_nettype none

module cpu_core
(
  input  wire                    CLK,
  input  wire                    rst,
  input  wire                    start,
  output bus_pkg::mem_req_t      mem_req,
  input  wire bus_pkg::word_t    mem_rdata,
  input  wire bus_pkg::word_t    io_in,
  output logic                   io_wr,
  output bus_pkg::io_write_t     io_out,
  output logic                   busy,
  output logic                   halted
);
  import isa_pkg::*;
  import bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_STOPPED
  } core_state_e;

  core_state_e state;
  address_t    pc;
  address_t    pc_next;
  instr_t      ir;
  instr_t      fetched;
  address_t    ir_addr;
  word_t       acc;
  word_t       acc_next;
  logic        acc_load;
  logic        zero;

  assign fetched = mem_rdata;  // instruction word during decode
  assign ir_addr = address_t'(ir.operand);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    mem_req = '0;
    case (state)
      ST_FETCH:  mem_req.address = pc;
      ST_DECODE: mem_req.address = address_t'(fetched.operand);  // operand for execute
      ST_EXECUTE:
        if (ir.opcode == OP_ST)
        begin
          mem_req.wr      = 1'b1;
          mem_req.address = ir_addr;
          mem_req.data    = acc;
        end
      default:   mem_req = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // execute datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    acc_next = acc;
    acc_load = 1'b0;
    if (state == ST_EXECUTE)
    begin
      acc_load = 1'b1;
      case (ir.opcode)
        OP_LDI:  acc_next = word_t'(ir.operand);
        OP_LD:   acc_next = mem_rdata;
        OP_ADD:  acc_next = acc + mem_rdata;
        OP_SUB:  acc_next = acc - mem_rdata;
        OP_AND:  acc_next = acc & mem_rdata;
        OP_OR:   acc_next = acc | mem_rdata;
        OP_XOR:  acc_next = acc ^ mem_rdata;
        OP_IN:   acc_next = io_in;
        default: acc_load = 1'b0;  // no acc change
      endcase
    end
  end

  always_comb
  begin
    case (ir.opcode)
      OP_JMP:  pc_next = ir_addr;
      OP_JZ:   pc_next = zero ? ir_addr : pc + address_t'(1);
      default: pc_next = pc + address_t'(1);  // wraps at 256
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
      pc    <= '0;
      acc   <= '0;
      zero  <= 1'b1;
    end
    else
    begin
      case (state)
        ST_IDLE, ST_STOPPED:
          if (start)
          begin
            state <= ST_FETCH;
            pc    <= '0;
          end
        ST_FETCH:  state <= ST_DECODE;
        ST_DECODE: state <= ST_EXECUTE;
        ST_EXECUTE:
        begin
          pc    <= pc_next;
          state <= (ir.opcode == OP_HALT) ? ST_STOPPED : ST_FETCH;
        end
        default:   state <= ST_IDLE;
      endcase
      if (acc_load)
      begin
        acc  <= acc_next;
        zero <= (acc_next == '0);
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (state == ST_DECODE)
    begin
      ir <= fetched;
    end
  end

  assign io_wr       = (state == ST_EXECUTE) && (ir.opcode == OP_OUT);
  assign io_out.port = port_t'(ir.operand);
  assign io_out.data = acc;

  assign busy   = (state == ST_FETCH) || (state == ST_DECODE) || (state == ST_EXECUTE);
  assign halted = (state == ST_STOPPED);

endmodule

`default_nettype wire

// ==== rtl/cpu_system.sv ====
// host writes are only safe while busy is low; start is ignored while busy
`default_nettype none

module cpu_system
(
  input  wire                    CLK,
  input  wire                    rst,
  input  wire                    start,
  input  wire bus_pkg::mem_req_t host_req,
  input  wire bus_pkg::word_t    io_in,
  output logic                   io_wr,
  output bus_pkg::io_write_t     io_out,
  output logic                   busy,
  output logic                   halted
);
  import bus_pkg::*;

  mem_req_t core_req;
  word_t    core_rdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // core
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  cpu_core u_core (
    .CLK       (CLK),
    .rst       (rst),
    .start     (start),
    .mem_req   (core_req),
    .mem_rdata (core_rdata),
    .io_in     (io_in),
    .io_wr     (io_wr),
    .io_out    (io_out),
    .busy      (busy),
    .halted    (halted)
  );

  // port a to the core, port b to the host loader
  boot_memory u_mem (
    .CLK     (CLK),
    .a_req   (core_req),
    .a_rdata (core_rdata),
    .b_req   (host_req)
  );

endmodule

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
// 4-bit opcode in the top bits; only the low address bits of the operand are decoded
`default_nettype none

`include "cpu_cfg.svh"

package isa_pkg;

  // instruction field widths
  localparam int OPCODE_BITS  = 4;
  localparam int OPERAND_BITS = `CPU_WORD_BITS - OPCODE_BITS;

  typedef logic [OPCODE_BITS-1:0]  opcode_t;
  typedef logic [OPERAND_BITS-1:0] operand_t;

  typedef struct packed {
    opcode_t  opcode;
    operand_t operand;
  } instr_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcodes, codes d and e unused
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam opcode_t OP_NOP  = 4'h0;
  localparam opcode_t OP_LDI  = 4'h1;  // acc = operand, zero-extended
  localparam opcode_t OP_LD   = 4'h2;
  localparam opcode_t OP_ST   = 4'h3;
  localparam opcode_t OP_ADD  = 4'h4;  // wraps
  localparam opcode_t OP_SUB  = 4'h5;
  localparam opcode_t OP_AND  = 4'h6;
  localparam opcode_t OP_OR   = 4'h7;
  localparam opcode_t OP_XOR  = 4'h8;
  localparam opcode_t OP_JMP  = 4'h9;
  localparam opcode_t OP_JZ   = 4'ha;  // taken when acc is zero
  localparam opcode_t OP_OUT  = 4'hb;
  localparam opcode_t OP_IN   = 4'hc;
  localparam opcode_t OP_HALT = 4'hf;

endpackage

`default_nettype wire

// ==== sim/tb_cpu_system.sv ====
// random forward-only programs of up to 64 words; stores stay in words 128 to 255
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu_system;
  timeunit 1ns;
  timeprecision 100ps;

  import bus_pkg::*;
  import isa_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DELAY    = 2;
  localparam int DEPTH          = 1 << `CPU_ADDRESS_BITS;
  localparam int PROGRAMS       = 40;
  localparam int MAX_LEN        = 64;
  localparam int TIMEOUT_CYCLES = PROGRAMS * (DEPTH + MAX_LEN * 3 + 40);

  logic      CLK = 1'b0;
  logic      rst;
  logic      start;
  mem_req_t  host_req;
  word_t     io_in;
  logic      io_wr;
  io_write_t io_out;
  logic      busy;
  logic      halted;

  word_t     image [DEPTH];  // model memory
  word_t     model_acc;
  word_t     io_in_value;
  io_write_t exp_q [$];
  int        value_errors = 0;
  int        other_errors = 0;
  int        cycle_count  = 0;
  int        instr_count;

  cpu_system dut (
    .CLK      (CLK),
    .rst      (rst),
    .start    (start),
    .host_req (host_req),
    .io_in    (io_in),
    .io_wr    (io_wr),
    .io_out   (io_out),
    .busy     (busy),
    .halted   (halted)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  always @(posedge CLK)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("simulation timed out after %0d cycles", cycle_count);
      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      $display("tests failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic step();
    @(posedge CLK);
    #DRIVE_DELAY;
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic push_expected(input port_t port, input word_t data);
    io_write_t w;
    w.port = port;
    w.data = data;
    exp_q.push_back(w);
  endtask

  task automatic load_memory();
    for (int a = 0; a < DEPTH; a++)
    begin
      step();
      host_req.wr      = 1'b1;
      host_req.address = address_t'(a);
      host_req.data    = image[address_t'(a)];
    end
    step();
    host_req = '0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // program generator
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic generate_program();
    int       len;
    int       op;
    operand_t operand;
    for (int a = 0; a < DEPTH; a++)
    begin
      image[address_t'(a)] = word_t'($urandom);
    end
    len = 1 + int'($urandom % MAX_LEN);
    for (int i = 0; i < len - 1; i++)
    begin
      op      = int'($urandom % 20);  // 0 to 14 plain, above that out
      operand = operand_t'($urandom);
      if (op >= 15)
        op = int'(OP_OUT);
      case (opcode_t'(op))
        OP_ST, OP_LD:
          operand[7:0] = address_t'(128 + int'($urandom % 8));  // few data words, so ld sees st
        OP_JMP, OP_JZ:
          operand[7:0] = address_t'(i + 1 + int'($urandom % (len - 1 - i)));
        default: ;
      endcase
      image[address_t'(i)] = {opcode_t'(op), operand};
    end
    image[address_t'(len - 1)] = {OP_HALT, operand_t'($urandom)};
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference interpreter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_model(output int count);
    address_t pc;
    address_t addr;
    instr_t   ins;
    bit       stop;
    pc    = '0;
    count = 0;
    stop  = 1'b0;
    while (!stop && count < 4 * DEPTH)
    begin
      ins  = image[pc];
      addr = address_t'(ins.operand);  // low bits only
      pc   = pc + address_t'(1);
      count++;
      case (ins.opcode)
        OP_LDI:  model_acc = word_t'(ins.operand);
        OP_LD:   model_acc = image[addr];
        OP_ST:   image[addr] = model_acc;
        OP_ADD:  model_acc = model_acc + image[addr];
        OP_SUB:  model_acc = model_acc - image[addr];
        OP_AND:  model_acc = model_acc & image[addr];
        OP_OR:   model_acc = model_acc | image[addr];
        OP_XOR:  model_acc = model_acc ^ image[addr];
        OP_JMP:  pc = addr;
        OP_JZ:   if (model_acc == '0) pc = addr;
        OP_OUT:  push_expected(port_t'(ins.operand), model_acc);
        OP_IN:   model_acc = io_in_value;
        OP_HALT: stop = 1'b1;
        default: ;
      endcase
    end
  endtask

  // start the core, check every output pulse, then the run length
  task automatic run_program(input int exp_instr, input bit extra_start);
    int        cycles;
    bit        done;
    io_write_t exp;
    step();
    start = 1'b1;
    step();
    start  = 1'b0;
    cycles = 1;
    done   = 1'b0;
    while (!done)
    begin
      @(negedge CLK);
      if (cycles == 1)
      begin
        compare_value("busy", 32'd1, 32'(busy));
        compare_value("halted", 32'd0, 32'(halted));
      end
      if (io_wr)
      begin
        if (exp_q.size() == 0)
        begin
          $display("unexpected io write to port %h with data %h", io_out.port, io_out.data);
          other_errors++;
        end
        else
        begin
          exp = exp_q.pop_front();
          compare_value("io_out.port", 32'(exp.port), 32'(io_out.port));
          compare_value("io_out.data", 32'(exp.data), 32'(io_out.data));
        end
      end
      if (halted)
        done = 1'b1;
      else
      begin
        step();
        cycles++;
        start = extra_start && (cycles == 2);  // ignored while busy
      end
    end
    compare_value("cycles to halted", 32'(3 * exp_instr + 1), 32'(cycles));
    compare_value("busy", 32'd0, 32'(busy));
    if (exp_q.size() != 0)
    begin
      $display("%0d expected io writes were missing when halted rose", exp_q.size());
      other_errors++;
    end
    exp_q.delete();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    void'($urandom(32'hc3ac9abc));
    rst       = 1'b1;
    start     = 1'b0;
    host_req  = '0;
    io_in     = '0;
    model_acc = '0;
    repeat (16) step();
    rst = 1'b0;
    step();
    compare_value("busy", 32'd0, 32'(busy));
    compare_value("halted", 32'd0, 32'(halted));
    compare_value("io_wr", 32'd0, 32'(io_wr));

    // boot program counts 5 down to 1 on port 1 in 32 instructions
    for (int n = 5; n >= 1; n--)
    begin
      push_expected(8'h01, word_t'(n));
    end
    run_program(32, 1'b0);
    model_acc = '0;  // count ends at zero

    for (int p = 0; p < PROGRAMS; p++)
    begin
      generate_program();
      io_in_value = word_t'($urandom);
      step();
      io_in = io_in_value;
      load_memory();
      run_model(instr_count);
      run_program(instr_count, p[0]);
    end

    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
